/* hdl/pjdl_pkg.sv */
// Widths, register map and state encodings of the PJDL controller
// Registers are 32 bit words; address bits 5 to 2 select the word

package pjdl_pkg;

    // -------------------------------------------------------------------------
    // Widths that carry a meaning
    // -------------------------------------------------------------------------
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [7:0]  line_byte_t;
    typedef logic [13:0] pad_ticks_t;
    typedef logic [11:0] data_ticks_t;
    typedef logic [7:0]  pjon_id_t;
    typedef logic [3:0]  reg_word_t;

    // -------------------------------------------------------------------------
    // Register word addresses
    // -------------------------------------------------------------------------
    localparam reg_word_t REG_PAD       = 4'd0;
    localparam reg_word_t REG_DATA      = 4'd1;
    localparam reg_word_t REG_ENABLE    = 4'd2;
    localparam reg_word_t REG_STREAM    = 4'd3;
    localparam reg_word_t REG_STATUS    = 4'd4;
    localparam reg_word_t REG_DEVICE_ID = 4'd5;
    localparam reg_word_t REG_ROUTER    = 4'd6;

    // Status word bits
    localparam int unsigned STAT_TX_EMPTY = 0;
    localparam int unsigned STAT_RX_AVAIL = 1;
    localparam int unsigned STAT_TX_BUSY  = 2;
    localparam int unsigned STAT_RX_BUSY  = 3;

    // Frame end marker in the stream word
    localparam int unsigned STREAM_LAST_BIT = 8;

    localparam pjon_id_t    BROADCAST_ID = 8'h00;
    // End of frame after this many bit times of low line
    localparam int unsigned IDLE_BITS    = 3;
    localparam int unsigned SYNC_STAGES  = 3;

    // -------------------------------------------------------------------------
    // State machines
    // -------------------------------------------------------------------------
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PAD,
        TX_SYNC,
        TX_BITS,
        TX_WAIT
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_PAD,
        RX_SYNC,
        RX_BITS,
        RX_HOLD
    } rx_state_e;

endpackage

/* hdl/pjdl_regs.sv */
// Register port grants in the request cycle and responds one cycle later
// Transmit and receive buffers hold one byte each
// Unmapped writes answer with err and unmapped reads return all ones

`timescale 1ns/1ps

module pjdl_regs (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  bus_req_i,
    input  logic                  bus_we_i,
    input  pjdl_pkg::bus_addr_t   bus_addr_i,
    input  pjdl_pkg::bus_data_t   bus_wdata_i,
    input  logic                  tx_ready_i,
    input  logic                  rx_valid_i,
    input  pjdl_pkg::line_byte_t  rx_byte_i,
    input  logic                  rx_last_i,
    input  logic                  tx_busy_i,
    input  logic                  rx_busy_i,
    output logic                  bus_gnt_o,
    output logic                  bus_rvalid_o,
    output pjdl_pkg::bus_data_t   bus_rdata_o,
    output logic                  bus_err_o,
    output logic                  tx_valid_o,
    output pjdl_pkg::line_byte_t  tx_byte_o,
    output logic                  tx_last_o,
    output logic                  rx_ready_o,
    output pjdl_pkg::pad_ticks_t  pad_ticks_o,
    output pjdl_pkg::data_ticks_t data_ticks_o,
    output logic                  enable_o,
    output pjdl_pkg::pjon_id_t    device_id_o,
    output logic                  router_mode_o
);
    import pjdl_pkg::*;

    // Registered request
    logic        req_q;
    logic        we_q;
    bus_addr_t   addr_q;
    bus_data_t   wdata_q;
    reg_word_t   word;
    logic        wr_en;
    logic        rd_stream;

    // Configuration
    pad_ticks_t  pad_q;
    data_ticks_t data_q;
    logic        enable_q;
    pjon_id_t    device_id_q;
    logic        router_q;

    // One-byte buffers
    logic        tx_valid_q;
    line_byte_t  tx_byte_q;
    logic        tx_last_q;
    logic        rx_avail_q;
    line_byte_t  rx_byte_q;
    logic        rx_last_q;

    bus_data_t   rsp_data;
    logic        rsp_err;

    assign bus_gnt_o = bus_req_i;
    assign word      = addr_q[5:2];
    assign wr_en     = req_q && we_q;
    assign rd_stream = req_q && !we_q && (word == REG_STREAM);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_q <= 1'b0;
        end else begin
            req_q <= bus_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_req_i) begin
            we_q    <= bus_we_i;
            addr_q  <= bus_addr_i;
            wdata_q <= bus_wdata_i;
        end
    end

    // -------------------------------------------------------------------------
    // Configuration writes
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pad_q       <= '0;
            data_q      <= '0;
            enable_q    <= 1'b0;
            device_id_q <= '0;
            router_q    <= 1'b0;
        end else if (wr_en) begin
            case (word)
                REG_PAD:       pad_q       <= pad_ticks_t'(wdata_q);
                REG_DATA:      data_q      <= data_ticks_t'(wdata_q);
                REG_ENABLE:    enable_q    <= wdata_q[0];
                REG_DEVICE_ID: device_id_q <= pjon_id_t'(wdata_q);
                REG_ROUTER:    router_q    <= wdata_q[0];
                default:       ;
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // Byte buffers
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tx_valid_q <= 1'b0;
            rx_avail_q <= 1'b0;
        end else begin
            // A new write wins over the handshake of the old byte
            if (wr_en && word == REG_STREAM) begin
                tx_valid_q <= 1'b1;
            end else if (tx_valid_q && tx_ready_i) begin
                tx_valid_q <= 1'b0;
            end
            if (rx_valid_i && rx_ready_o) begin
                rx_avail_q <= 1'b1;
            end else if (rd_stream) begin
                rx_avail_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en && word == REG_STREAM) begin
            tx_byte_q <= line_byte_t'(wdata_q);
            tx_last_q <= wdata_q[STREAM_LAST_BIT];
        end
        if (rx_valid_i && rx_ready_o) begin
            rx_byte_q <= rx_byte_i;
            rx_last_q <= rx_last_i;
        end
    end

    // Response built from the registered request
    always_comb begin
        rsp_data = '0;
        rsp_err  = 1'b0;
        if (req_q && we_q) begin
            rsp_err = !(word inside {REG_PAD, REG_DATA, REG_ENABLE, REG_STREAM,
                                     REG_DEVICE_ID, REG_ROUTER});
        end else if (req_q) begin
            case (word)
                REG_PAD:       rsp_data = bus_data_t'(pad_q);
                REG_DATA:      rsp_data = bus_data_t'(data_q);
                REG_ENABLE:    rsp_data = bus_data_t'(enable_q);
                REG_STREAM: begin
                    rsp_data[7:0]            = rx_byte_q;
                    rsp_data[STREAM_LAST_BIT] = rx_last_q;
                end
                REG_STATUS: begin
                    rsp_data[STAT_TX_EMPTY] = !tx_valid_q;
                    rsp_data[STAT_RX_AVAIL] = rx_avail_q;
                    rsp_data[STAT_TX_BUSY]  = tx_busy_i;
                    rsp_data[STAT_RX_BUSY]  = rx_busy_i;
                end
                REG_DEVICE_ID: rsp_data = bus_data_t'(device_id_q);
                REG_ROUTER:    rsp_data = bus_data_t'(router_q);
                default:       rsp_data = '1;
            endcase
        end
    end

    assign bus_rvalid_o  = req_q;
    assign bus_rdata_o   = rsp_data;
    assign bus_err_o     = rsp_err;
    assign tx_valid_o    = tx_valid_q;
    assign tx_byte_o     = tx_byte_q;
    assign tx_last_o     = tx_last_q;
    assign rx_ready_o    = !rx_avail_q;
    assign pad_ticks_o   = pad_q;
    assign data_ticks_o  = data_q;
    assign enable_o      = enable_q;
    assign device_id_o   = device_id_q;
    assign router_mode_o = router_q;

    // A byte handed to the transmitter starts a frame on the next cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
        tx_valid_o && tx_ready_i |=> tx_busy_i)
        else $error("transmitter not busy after taking a byte");

endmodule

/* hdl/pjdl_tx.sv */
// PJDL byte serializer sends a high pad, a low sync bit and 8 data bits LSB first
// Tick values of zero are not supported
// Enable low clears the FSM and releases the line

`timescale 1ns/1ps

module pjdl_tx (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  enable_i,
    input  pjdl_pkg::pad_ticks_t  pad_ticks_i,
    input  pjdl_pkg::data_ticks_t data_ticks_i,
    input  logic                  tx_valid_i,
    input  pjdl_pkg::line_byte_t  tx_byte_i,
    input  logic                  tx_last_i,
    output logic                  tx_ready_o,
    output logic                  busy_o,
    output logic                  pjon_o,
    output logic                  pjon_en_o
);
    import pjdl_pkg::*;

    tx_state_e  state_q;
    pad_ticks_t tick_q;
    logic [2:0] bit_q;
    line_byte_t shift_q;
    logic       last_q;
    logic       hold;
    logic       tick_done;
    logic       byte_done;
    logic       take;
    pad_ticks_t bit_len;

    assign hold      = reset_i || !enable_i;
    assign bit_len   = pad_ticks_t'(data_ticks_i) - 1'b1;
    assign tick_done = (tick_q == '0);
    assign byte_done = (state_q == TX_BITS) && tick_done && (bit_q == 3'd7);

    // Next byte is taken as its pad starts
    assign tx_ready_o = enable_i && ((state_q == TX_IDLE) || (state_q == TX_WAIT) ||
                                     (byte_done && !last_q));
    assign take       = tx_valid_i && tx_ready_o;

    always_ff @(posedge clk_i) begin
        if (hold) begin
            state_q <= TX_IDLE;
            tick_q  <= '0;
            bit_q   <= '0;
            last_q  <= 1'b0;
        end else begin
            if (!tick_done) begin
                tick_q <= tick_q - 1'b1;
            end
            case (state_q)
                TX_PAD: begin
                    if (tick_done) begin
                        state_q <= TX_SYNC;
                        tick_q  <= bit_len;
                    end
                end
                TX_SYNC: begin
                    if (tick_done) begin
                        state_q <= TX_BITS;
                        tick_q  <= bit_len;
                        bit_q   <= '0;
                    end
                end
                TX_BITS: begin
                    if (tick_done) begin
                        bit_q  <= bit_q + 1'b1;
                        tick_q <= bit_len;
                        if (bit_q == 3'd7) begin
                            // Without a waiting byte the line stays driven low
                            state_q <= last_q ? TX_IDLE : TX_WAIT;
                        end
                    end
                end
                default: ;
            endcase
            if (take) begin
                state_q <= TX_PAD;
                tick_q  <= pad_ticks_i - 1'b1;
                last_q  <= tx_last_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            shift_q <= tx_byte_i;
        end else if (state_q == TX_BITS && tick_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign busy_o    = (state_q != TX_IDLE);
    assign pjon_en_o = busy_o;
    assign pjon_o    = (state_q == TX_PAD) || ((state_q == TX_BITS) && shift_q[0]);

    // Zero tick lengths would wrap the counters
    assert property (@(posedge clk_i) disable iff (reset_i)
        take |-> (pad_ticks_i != '0) && (data_ticks_i != '0))
        else $error("byte taken with a zero pad or bit length");

endmodule

/* hdl/pjdl_rx.sv */
// PJDL receiver: pad accepted after half of pad_ticks of high line
// Bits are sampled one bit time apart, starting mid sync bit
// No back-pressure: rx_valid_o is a one-cycle pulse

`timescale 1ns/1ps

module pjdl_rx (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  enable_i,
    input  pjdl_pkg::pad_ticks_t  pad_ticks_i,
    input  pjdl_pkg::data_ticks_t data_ticks_i,
    input  logic                  pjon_i,
    output logic                  rx_valid_o,
    output pjdl_pkg::line_byte_t  rx_byte_o,
    output logic                  rx_last_o,
    output logic                  busy_o
);
    import pjdl_pkg::*;

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   line;
    rx_state_e              state_q;
    pad_ticks_t             cnt_q;
    logic [2:0]             bit_q;
    line_byte_t             shift_q;
    logic                   hold;
    logic                   sample;
    pad_ticks_t             data_len;
    pad_ticks_t             idle_limit;

    assign hold       = reset_i || !enable_i;
    assign line       = sync_q[SYNC_STAGES-1];
    assign data_len   = pad_ticks_t'(data_ticks_i);
    assign idle_limit = data_len * pad_ticks_t'(IDLE_BITS);
    assign sample     = (state_q == RX_BITS) && (cnt_q == data_len - 1'b1);

    always_ff @(posedge clk_i) begin
        if (hold) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], pjon_i};
        end
    end

    // -------------------------------------------------------------------------
    // Frame FSM
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (hold) begin
            state_q    <= RX_IDLE;
            cnt_q      <= '0;
            bit_q      <= '0;
            rx_valid_o <= 1'b0;
            rx_last_o  <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (cnt_q != '1) begin
                cnt_q <= cnt_q + 1'b1;
            end
            case (state_q)
                RX_IDLE: begin
                    if (line) begin
                        state_q <= RX_PAD;
                        cnt_q   <= '0;
                    end
                end
                RX_PAD: begin
                    if (!line) begin
                        cnt_q   <= '0;
                        state_q <= (cnt_q >= (pad_ticks_i >> 1)) ? RX_SYNC : RX_IDLE;
                    end
                end
                RX_SYNC: begin
                    // Mid sync bit, line must still be low
                    if (cnt_q == (data_len >> 1)) begin
                        state_q <= line ? RX_IDLE : RX_BITS;
                        cnt_q   <= '0;
                        bit_q   <= '0;
                    end
                end
                RX_BITS: begin
                    if (sample) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= RX_HOLD;
                        end
                    end
                end
                RX_HOLD: begin
                    // High line past the last bit starts the next pad
                    if (line && cnt_q >= data_len) begin
                        state_q    <= RX_PAD;
                        cnt_q      <= '0;
                        rx_valid_o <= 1'b1;
                        rx_last_o  <= 1'b0;
                    end else if (!line && cnt_q >= idle_limit) begin
                        state_q    <= RX_IDLE;
                        rx_valid_o <= 1'b1;
                        rx_last_o  <= 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample) begin
            shift_q <= {line, shift_q[7:1]};
        end
        if (state_q == RX_HOLD) begin
            rx_byte_o <= shift_q;
        end
    end

    assign busy_o = (state_q != RX_IDLE);

endmodule

/* hdl/pjon_rx_filter.sv */
// Receiver-id filter: first byte of a frame decides for the whole frame
// Output holds one byte; a newer byte overwrites an unread one

`timescale 1ns/1ps

module pjon_rx_filter (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 enable_i,
    input  pjdl_pkg::pjon_id_t   device_id_i,
    input  logic                 router_mode_i,
    input  logic                 in_valid_i,
    input  pjdl_pkg::line_byte_t in_byte_i,
    input  logic                 in_last_i,
    input  logic                 out_ready_i,
    output logic                 in_ready_o,
    output logic                 out_valid_o,
    output pjdl_pkg::line_byte_t out_byte_o,
    output logic                 out_last_o
);
    import pjdl_pkg::*;

    logic first_q;
    logic pass_q;
    logic id_match;
    logic pass_now;

    assign id_match   = (in_byte_i == device_id_i) || (in_byte_i == BROADCAST_ID) ||
                        router_mode_i;
    assign pass_now   = first_q ? id_match : pass_q;
    // Dropped bytes are always accepted
    assign in_ready_o = !pass_now || !out_valid_o || out_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i || !enable_i) begin
            first_q     <= 1'b1;
            pass_q      <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            if (out_valid_o && out_ready_i) begin
                out_valid_o <= 1'b0;
            end
            if (in_valid_i) begin
                first_q <= in_last_i;
                pass_q  <= pass_now;
                if (pass_now) begin
                    out_valid_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && pass_now) begin
            out_byte_o <= in_byte_i;
            out_last_o <= in_last_i;
        end
    end

endmodule

/* hdl/pjdl_top.sv */
// PJDL one-wire controller with register port
// pjon_o is meaningful only while pjon_en_o is high

`timescale 1ns/1ps

module pjdl_top (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                bus_req_i,
    input  logic                bus_we_i,
    input  pjdl_pkg::bus_addr_t bus_addr_i,
    input  pjdl_pkg::bus_data_t bus_wdata_i,
    input  logic                pjon_i,
    output logic                bus_gnt_o,
    output logic                bus_rvalid_o,
    output pjdl_pkg::bus_data_t bus_rdata_o,
    output logic                bus_err_o,
    output logic                pjon_o,
    output logic                pjon_en_o
);
    import pjdl_pkg::*;

    pad_ticks_t  pad_ticks;
    data_ticks_t data_ticks;
    logic        enable;
    pjon_id_t    device_id;
    logic        router_mode;

    logic        tx_valid;
    line_byte_t  tx_byte;
    logic        tx_last;
    logic        tx_ready;
    logic        tx_busy;

    logic        rx_valid;
    line_byte_t  rx_byte;
    logic        rx_last;
    logic        rx_busy;

    logic        flt_valid;
    line_byte_t  flt_byte;
    logic        flt_last;
    logic        flt_ready;

    pjdl_regs regs0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .bus_req_i     (bus_req_i),
        .bus_we_i      (bus_we_i),
        .bus_addr_i    (bus_addr_i),
        .bus_wdata_i   (bus_wdata_i),
        .tx_ready_i    (tx_ready),
        .rx_valid_i    (flt_valid),
        .rx_byte_i     (flt_byte),
        .rx_last_i     (flt_last),
        .tx_busy_i     (tx_busy),
        .rx_busy_i     (rx_busy),
        .bus_gnt_o     (bus_gnt_o),
        .bus_rvalid_o  (bus_rvalid_o),
        .bus_rdata_o   (bus_rdata_o),
        .bus_err_o     (bus_err_o),
        .tx_valid_o    (tx_valid),
        .tx_byte_o     (tx_byte),
        .tx_last_o     (tx_last),
        .rx_ready_o    (flt_ready),
        .pad_ticks_o   (pad_ticks),
        .data_ticks_o  (data_ticks),
        .enable_o      (enable),
        .device_id_o   (device_id),
        .router_mode_o (router_mode)
    );

    pjdl_tx tx0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .enable_i     (enable),
        .pad_ticks_i  (pad_ticks),
        .data_ticks_i (data_ticks),
        .tx_valid_i   (tx_valid),
        .tx_byte_i    (tx_byte),
        .tx_last_i    (tx_last),
        .tx_ready_o   (tx_ready),
        .busy_o       (tx_busy),
        .pjon_o       (pjon_o),
        .pjon_en_o    (pjon_en_o)
    );

    pjdl_rx rx0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .enable_i     (enable),
        .pad_ticks_i  (pad_ticks),
        .data_ticks_i (data_ticks),
        .pjon_i       (pjon_i),
        .rx_valid_o   (rx_valid),
        .rx_byte_o    (rx_byte),
        .rx_last_o    (rx_last),
        .busy_o       (rx_busy)
    );

    // The wire cannot be stalled, so the receiver ignores in_ready
    pjon_rx_filter filter0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (enable),
        .device_id_i   (device_id),
        .router_mode_i (router_mode),
        .in_valid_i    (rx_valid),
        .in_byte_i     (rx_byte),
        .in_last_i     (rx_last),
        .out_ready_i   (flt_ready),
        .in_ready_o    (),
        .out_valid_o   (flt_valid),
        .out_byte_o    (flt_byte),
        .out_last_o    (flt_last)
    );

endmodule

/* bench/pjdl_tb.sv */
// Directed testbench for the PJDL controller with a loopback line model
// Line timing is fixed at pad_ticks 40 and data_ticks 16
// The host polls status; no interrupt is modelled

`timescale 1ns/1ps

module pjdl_tb;
    import pjdl_pkg::*;

    localparam int unsigned PAD_TICKS         = 40;
    localparam int unsigned DATA_TICKS        = 16;
    localparam int unsigned FRAME_BYTE_CYCLES = PAD_TICKS + 9 * DATA_TICKS;
    localparam int unsigned TOTAL_FRAME_BYTES = 17;
    localparam int unsigned TAIL_CYCLES       = 64;
    localparam int unsigned WATCHDOG_CYCLES   =
        2 * TOTAL_FRAME_BYTES * FRAME_BYTE_CYCLES + 2000;

    logic        clk = 1'b0;
    logic        reset_i;
    logic        bus_req_i;
    logic        bus_we_i;
    bus_addr_t   bus_addr_i;
    bus_data_t   bus_wdata_i;
    logic        pjon_line;
    logic        bus_gnt_o;
    logic        bus_rvalid_o;
    bus_data_t   bus_rdata_o;
    logic        bus_err_o;
    logic        pjon_o;
    logic        pjon_en_o;

    int unsigned errors      = 0;
    int unsigned checks      = 0;
    int unsigned cycle_count = 0;
    logic [31:0] rng_state   = 32'h755a_0408;
    line_byte_t  frame_q[$];

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Loopback: the line reads back what the DUT drives, low when released
    assign pjon_line = pjon_en_o ? pjon_o : 1'b0;

    pjdl_top dut0 (
        .clk_i        (clk),
        .reset_i      (reset_i),
        .bus_req_i    (bus_req_i),
        .bus_we_i     (bus_we_i),
        .bus_addr_i   (bus_addr_i),
        .bus_wdata_i  (bus_wdata_i),
        .pjon_i       (pjon_line),
        .bus_gnt_o    (bus_gnt_o),
        .bus_rvalid_o (bus_rvalid_o),
        .bus_rdata_o  (bus_rdata_o),
        .bus_err_o    (bus_err_o),
        .pjon_o       (pjon_o),
        .pjon_en_o    (pjon_en_o)
    );

    // ------------------------------------------------------------------------
    // Checking and stimulus helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input bus_data_t actual,
                               input bus_data_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic bus_data_t make_stream_word(input line_byte_t b, input logic last);
        return {23'd0, last, b};
    endfunction

    // First byte is the receiver id, the rest is pseudo random
    task automatic build_frame(input line_byte_t first, input int unsigned n);
        frame_q.delete();
        frame_q.push_back(first);
        for (int unsigned i = 1; i < n; i++) begin
            rng_state = xorshift32(rng_state);
            frame_q.push_back(rng_state[7:0]);
        end
    endtask

    // One access: grant in the request cycle, response on the next cycle
    task automatic bus_access(input logic we, input reg_word_t word, input bus_data_t wdata,
                              output bus_data_t rdata, output logic err);
        @(negedge clk);
        if (bus_rvalid_o) begin
            report_error("response valid without a request in the previous cycle");
        end
        bus_req_i   = 1'b1;
        bus_we_i    = we;
        bus_addr_i  = {26'd0, word, 2'b00};
        bus_wdata_i = wdata;
        @(posedge clk);
        if (!bus_gnt_o) begin
            report_error("request not granted in its own cycle");
        end
        @(negedge clk);
        if (!bus_rvalid_o) begin
            report_error("no response one cycle after the request");
        end
        rdata     = bus_rdata_o;
        err       = bus_err_o;
        bus_req_i = 1'b0;
        bus_we_i  = 1'b0;
    endtask

    task automatic bus_write(input reg_word_t word, input bus_data_t data, input logic exp_err);
        bus_data_t rdata;
        logic      err;
        bus_access(1'b1, word, data, rdata, err);
        check_value("bus_err_o", bus_data_t'(err), bus_data_t'(exp_err));
    endtask

    task automatic bus_read(input reg_word_t word, output bus_data_t data);
        logic err;
        bus_access(1'b0, word, '0, data, err);
        check_value("bus_err_o", bus_data_t'(err), 32'd0);
    endtask

    task automatic write_and_read_back(input reg_word_t word, input bus_data_t value,
                                       input string name);
        bus_data_t v;
        bus_write(word, value, 1'b0);
        bus_read(word, v);
        check_value(name, v, value);
    endtask

    // Sends frame_q and collects what comes back, both by polling status
    task automatic transfer_frame(input logic expect_rx);
        int unsigned n;
        int unsigned sent;
        int unsigned start;
        int unsigned quiet_limit;
        line_byte_t  got_byte[$];
        logic        got_last[$];
        bus_data_t   status;
        bus_data_t   word;
        logic        done;
        n           = frame_q.size();
        sent        = 0;
        start       = cycle_count;
        quiet_limit = n * FRAME_BYTE_CYCLES + IDLE_BITS * DATA_TICKS + TAIL_CYCLES;
        done        = 1'b0;
        while (!done) begin
            bus_read(REG_STATUS, status);
            if (status[STAT_TX_EMPTY] && sent < n) begin
                bus_write(REG_STREAM, make_stream_word(frame_q[sent], sent == n - 1), 1'b0);
                sent++;
            end
            if (status[STAT_RX_AVAIL]) begin
                bus_read(REG_STREAM, word);
                got_byte.push_back(word[7:0]);
                got_last.push_back(word[STREAM_LAST_BIT]);
            end
            if (expect_rx) begin
                done = (sent == n) && (got_byte.size() >= n ||
                       (got_last.size() > 0 && got_last[got_last.size() - 1]));
            end else begin
                done = (sent == n) && (cycle_count - start >= quiet_limit);
            end
        end
        if (expect_rx) begin
            check_value("rx byte count", bus_data_t'(got_byte.size()), bus_data_t'(n));
            for (int unsigned i = 0; i < n && i < got_byte.size(); i++) begin
                check_value($sformatf("rx byte %0d", i), bus_data_t'(got_byte[i]),
                            bus_data_t'(frame_q[i]));
                check_value($sformatf("rx last %0d", i), bus_data_t'(got_last[i]),
                            bus_data_t'(i == n - 1));
            end
        end else if (got_byte.size() != 0) begin
            report_error("a frame for another device raised rx-available");
        end
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic reset_and_config();
        bus_data_t v;
        bus_read(REG_PAD, v);
        check_value("pad ticks after reset", v, 32'd0);
        bus_read(REG_DATA, v);
        check_value("data ticks after reset", v, 32'd0);
        bus_read(REG_ENABLE, v);
        check_value("enable after reset", v, 32'd0);
        bus_read(REG_DEVICE_ID, v);
        check_value("device id after reset", v, 32'd0);
        bus_read(REG_ROUTER, v);
        check_value("router mode after reset", v, 32'd0);
        bus_read(REG_STATUS, v);
        check_value("status after reset", v, 32'd1 << STAT_TX_EMPTY);
        write_and_read_back(REG_PAD, PAD_TICKS, "pad ticks");
        write_and_read_back(REG_DATA, DATA_TICKS, "data ticks");
        write_and_read_back(REG_DEVICE_ID, 32'h2A, "device id");
        write_and_read_back(REG_ROUTER, 32'd1, "router mode");
        write_and_read_back(REG_ROUTER, 32'd0, "router mode");
        write_and_read_back(REG_ENABLE, 32'd1, "enable");
    endtask

    task automatic unmapped_words();
        bus_data_t v;
        bus_write(REG_STATUS, 32'h1, 1'b1);
        bus_write(4'd9, 32'h5, 1'b1);
        bus_read(4'd9, v);
        check_value("word 9 read data", v, 32'hFFFF_FFFF);
    endtask

    task automatic addressed_loopback();
        build_frame(8'h2A, 5);
        transfer_frame(1'b1);
        // Driver released once the last byte is out
        check_value("pjon_en_o", bus_data_t'(pjon_en_o), 32'd0);
    endtask

    task automatic foreign_frame_dropped();
        build_frame(8'h17, 4);
        transfer_frame(1'b0);
        build_frame(BROADCAST_ID, 4);
        transfer_frame(1'b1);
    endtask

    task automatic router_and_disable();
        bus_data_t v;
        logic      seen_en;
        bus_write(REG_ROUTER, 32'd1, 1'b0);
        build_frame(8'h17, 4);
        transfer_frame(1'b1);
        bus_write(REG_ENABLE, 32'd0, 1'b0);
        bus_write(REG_STREAM, make_stream_word(8'h55, 1'b1), 1'b0);
        seen_en = 1'b0;
        repeat (FRAME_BYTE_CYCLES) begin
            @(negedge clk);
            seen_en = seen_en | pjon_en_o;
        end
        check_value("pjon_en_o while disabled", bus_data_t'(seen_en), 32'd0);
        bus_read(REG_STATUS, v);
        check_value("status tx empty while disabled", bus_data_t'(v[STAT_TX_EMPTY]), 32'd0);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        reset_i     = 1'b1;
        bus_req_i   = 1'b0;
        bus_we_i    = 1'b0;
        bus_addr_i  = '0;
        bus_wdata_i = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        reset_and_config();
        unmapped_words();
        addressed_loopback();
        foreign_frame_dropped();
        router_and_disable();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* tb.f */
hdl/pjdl_pkg.sv
hdl/pjdl_regs.sv
hdl/pjdl_tx.sv
hdl/pjdl_rx.sv
hdl/pjon_rx_filter.sv
hdl/pjdl_top.sv
bench/pjdl_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module pjdl_tb -Mdir obj_dir -o pjdl_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/pjdl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
